/* common/ahb_pkg.sv */
// ----------------------------------------------------------
// AHB protocol constants and bundle types
// HTRANS and HRESP codes, decode address width,
// address-phase request and slave return structs
// ----------------------------------------------------------

package ahb_pkg;

    // ------------------------------------------------------
    // Transfer and response codes
    // ------------------------------------------------------
    localparam logic [1:0] HTRANS_IDLE   = 2'b00;
    localparam logic [1:0] HTRANS_BUSY   = 2'b01;
    localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
    localparam logic [1:0] HTRANS_SEQ    = 2'b11;

    localparam logic [1:0] HRESP_OKAY    = 2'b00;
    localparam logic [1:0] HRESP_ERROR   = 2'b01;

    localparam int DATA_W       = 32;   // HRDATA width
    localparam int DEC_ADDR_LSB = 10;   // 1 KB decode granule

    // HADDR[31:10], 22 bits
    typedef logic [31:DEC_ADDR_LSB] dec_addr_t;

    // ------------------------------------------------------
    // Bundles
    // ------------------------------------------------------
    // Input port address phase
    typedef struct packed {
        logic       sel;    // HSEL
        dec_addr_t  addr;   // Upper HADDR bits
        logic [1:0] trans;  // HTRANS
    } addr_req_t;

    // Return path of one slave or output port
    typedef struct packed {
        logic              readyout;  // HREADYOUT
        logic [1:0]        resp;      // HRESP
        logic [DATA_W-1:0] rdata;     // HRDATA
    } slv_rsp_t;

endpackage

/* common/matrix_map_pkg.sv */
// ----------------------------------------------------------
// Bus matrix address map
// Output port count, port-select encoding,
// per-port decode region bounds
// ----------------------------------------------------------

package matrix_map_pkg;

    localparam int NUM_PORTS = 5;   // Output ports MI0..MI4

    // Port select encoding, default slave sits apart at 8
    typedef enum logic [3:0] {
        PORT_MI0 = 4'd0,
        PORT_MI1 = 4'd1,
        PORT_MI2 = 4'd2,
        PORT_MI3 = 4'd3,
        PORT_MI4 = 4'd4,
        PORT_DFT = 4'd8
    } port_sel_t;

    // One bit per output port
    typedef logic [NUM_PORTS-1:0] port_vec_t;

    // Vector index to port code
    localparam port_sel_t PORT_ID [NUM_PORTS] = '{
        PORT_MI0, PORT_MI1, PORT_MI2, PORT_MI3, PORT_MI4
    };

    // ------------------------------------------------------
    // Region table in 1 KB units, bounds inclusive
    // ------------------------------------------------------
    localparam ahb_pkg::dec_addr_t REGION_BASE [NUM_PORTS] = '{
        22'h000000,     // MI0 from 0x0000_0000
        22'h080000,     // MI1 from 0x2000_0000
        22'h100000,     // MI2 from 0x4000_0000
        22'h100040,     // MI3 from 0x4001_0000
        22'h100080      // MI4 from 0x4002_0000
    };

    localparam ahb_pkg::dec_addr_t REGION_LIMIT [NUM_PORTS] = '{
        22'h0003FF,     // MI0 to 0x000F_FFFF
        22'h0800FF,     // MI1 to 0x2003_FFFF
        22'h10003F,     // MI2 to 0x4000_FFFF
        22'h10007F,     // MI3 to 0x4001_FFFF
        22'h1000BF      // MI4 to 0x4002_FFFF
    };

endpackage

/* decode/matrix_addr_stage.sv */
// ----------------------------------------------------------
// Address-phase decode of one matrix input
// Region compare, output port choice,
// HSEL generation and active flag mux
// ----------------------------------------------------------

`timescale 1ns/10ps

module matrix_addr_stage (
    input  ahb_pkg::addr_req_t        addr_req,   // Input port address phase
    input  matrix_map_pkg::port_sel_t data_port,  // Port owning the data phase
    input  matrix_map_pkg::port_vec_t active_in,  // Per-port active flags
    output matrix_map_pkg::port_sel_t addr_port,  // Decoded port
    output matrix_map_pkg::port_vec_t sel_out,    // HSEL per output port
    output logic                      sel_dft,    // HSEL to default slave
    output logic                      active      // Active flag of decoded port
);

    matrix_map_pkg::port_vec_t region_hit;  // Address inside region i

    // ------------------------------------------------------
    // Region compare
    // ------------------------------------------------------
    always_comb
    begin
        for (int i = 0; i < matrix_map_pkg::NUM_PORTS; i++)
        begin
            region_hit[i] = (addr_req.addr >= matrix_map_pkg::REGION_BASE[i]) &&
                            (addr_req.addr <= matrix_map_pkg::REGION_LIMIT[i]);
        end
    end

    // ------------------------------------------------------
    // Port choice
    // ------------------------------------------------------
    // Unmapped addresses fall back first, then the region hits
    // overwrite from the top so that the lowest port wins
    always_comb
    begin
        if (addr_req.trans == ahb_pkg::HTRANS_IDLE)
            addr_port = data_port;                  // IDLE stays put
        else
            addr_port = matrix_map_pkg::PORT_DFT;   // Unmapped access
        for (int i = matrix_map_pkg::NUM_PORTS - 1; i >= 0; i--)
        begin
            if (region_hit[i])
                addr_port = matrix_map_pkg::PORT_ID[i];
        end
    end

    // ------------------------------------------------------
    // Selects
    // ------------------------------------------------------
    always_comb
    begin
        for (int i = 0; i < matrix_map_pkg::NUM_PORTS; i++)
        begin
            // Only while the input port itself is selected
            sel_out[i] = addr_req.sel &&
                         (addr_port == matrix_map_pkg::PORT_ID[i]);
        end
    end

    assign sel_dft = addr_req.sel && (addr_port == matrix_map_pkg::PORT_DFT);

    // ------------------------------------------------------
    // Active flag
    // ------------------------------------------------------
    always_comb
    begin
        active = 1'b1;  // Default slave is always ready to take a transfer
        for (int i = 0; i < matrix_map_pkg::NUM_PORTS; i++)
        begin
            if (addr_port == matrix_map_pkg::PORT_ID[i])
                active = active_in[i];
        end
    end

endmodule

/* decode/matrix_data_stage.sv */
// ----------------------------------------------------------
// Data-phase tracking of one matrix input
// Registered data-phase port and the return mux
// ----------------------------------------------------------

`timescale 1ns/10ps

module matrix_data_stage (
    input  logic                      HCLK,
    input  logic                      HRESETn,
    input  logic                      hready_s,   // Input port HREADY
    input  matrix_map_pkg::port_sel_t addr_port,  // Decoded address-phase port
    input  ahb_pkg::slv_rsp_t [matrix_map_pkg::NUM_PORTS-1:0] port_rsp,
    input  ahb_pkg::slv_rsp_t         dft_rsp,    // Default slave return
    output matrix_map_pkg::port_sel_t data_port,  // Port owning the data phase
    output ahb_pkg::slv_rsp_t         s_rsp       // Return to the input port
);

    // ------------------------------------------------------
    // Data-phase port register
    // ------------------------------------------------------
    // Loads on the input HREADY rather than the returned
    // HREADYOUT, so a held input keeps the return mux fixed
    always_ff @(posedge HCLK)
    begin
        if (!HRESETn)
            data_port <= matrix_map_pkg::PORT_MI0;
        else if (hready_s)
            data_port <= addr_port;     // Address phase accepted
    end

    // ------------------------------------------------------
    // Return mux
    // ------------------------------------------------------
    always_comb
    begin
        // Default slave path
        s_rsp       = dft_rsp;
        s_rsp.rdata = '0;                // No read data from default slave
        for (int i = 0; i < matrix_map_pkg::NUM_PORTS; i++)
        begin
            if (data_port == matrix_map_pkg::PORT_ID[i])
                s_rsp = port_rsp[i];    // Whole bundle of port i
        end
    end

endmodule

/* default_slave/ahb_default_slave.sv */
// ----------------------------------------------------------
// Default slave for unmapped addresses
// Two-cycle ERROR response to NONSEQ and SEQ,
// OKAY with no wait states otherwise
// ----------------------------------------------------------

`timescale 1ns/10ps

module ahb_default_slave (
    input  logic              HCLK,
    input  logic              HRESETn,
    input  logic              hsel,     // Selected by the decoder
    input  logic [1:0]        htrans,   // Input port HTRANS
    input  logic              hready,   // Input port HREADY
    output ahb_pkg::slv_rsp_t rsp       // HREADYOUT, HRESP, HRDATA
);

    logic err_req;      // Accepted transfer that must fail
    logic err_first;    // First ERROR cycle, wait state
    logic err_last;     // Second ERROR cycle, completes

    // IDLE and BUSY never produce an error
    assign err_req = hsel && hready &&
                     ((htrans == ahb_pkg::HTRANS_NONSEQ) ||
                      (htrans == ahb_pkg::HTRANS_SEQ));

    // ------------------------------------------------------
    // Response sequencing
    // ------------------------------------------------------
    always_ff @(posedge HCLK)
    begin
        if (!HRESETn)
        begin
            err_first <= 1'b0;
            err_last  <= 1'b0;
        end
        else
        begin
            err_first <= err_req;
            // A fresh request restarts the sequence
            err_last  <= err_first && !err_req;
        end
    end

    always_comb
    begin
        rsp.readyout = !err_first;      // Low only in the first cycle
        rsp.resp     = (err_first || err_last) ? ahb_pkg::HRESP_ERROR
                                               : ahb_pkg::HRESP_OKAY;
        rsp.rdata    = '0;
    end

endmodule

/* logic/ahb_matrix_decode.sv */
// ----------------------------------------------------------
// Per-input decode stage of the AHB bus matrix
// Address stage, data stage and default slave
// ----------------------------------------------------------

`timescale 1ns/10ps

module ahb_matrix_decode (
    input  logic                      HCLK,
    input  logic                      HRESETn,
    // Input stage side
    input  logic                      hready_s,   // Input port HREADY
    input  ahb_pkg::addr_req_t        addr_req,   // Address-phase bundle
    // Output stage side
    input  matrix_map_pkg::port_vec_t active_in,  // Per-port active flags
    input  ahb_pkg::slv_rsp_t [matrix_map_pkg::NUM_PORTS-1:0] port_rsp,
    output matrix_map_pkg::port_vec_t sel_out,    // HSEL per output port
    // Back to the input stage
    output logic                      active,     // Active flag of chosen port
    output ahb_pkg::slv_rsp_t         s_rsp       // Selected return bundle
);

    // ------------------------------------------------------
    // Internal wiring
    // ------------------------------------------------------
    matrix_map_pkg::port_sel_t addr_port;   // Address-phase port
    matrix_map_pkg::port_sel_t data_port;   // Data-phase port
    logic                      sel_dft;     // Default slave HSEL
    ahb_pkg::slv_rsp_t         dft_rsp;     // Default slave return

    // Address phase
    matrix_addr_stage u_matrix_addr_stage (
        .addr_req  (addr_req),
        .data_port (data_port),
        .active_in (active_in),
        .addr_port (addr_port),
        .sel_out   (sel_out),
        .sel_dft   (sel_dft),
        .active    (active)
    );

    // Data phase
    matrix_data_stage u_matrix_data_stage (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .hready_s  (hready_s),
        .addr_port (addr_port),
        .port_rsp  (port_rsp),
        .dft_rsp   (dft_rsp),
        .data_port (data_port),
        .s_rsp     (s_rsp)
    );

    // Catches everything outside the map
    ahb_default_slave u_ahb_default_slave (
        .HCLK    (HCLK),
        .HRESETn (HRESETn),
        .hsel    (sel_dft),
        .htrans  (addr_req.trans),
        .hready  (hready_s),
        .rsp     (dft_rsp)
    );

endmodule

/* tests/ahb_matrix_decode_sva.sv */
// ----------------------------------------------------------
// Concurrent assertions for the matrix decode stage
// HSEL exclusivity and default slave ERROR sequence
// ----------------------------------------------------------

`timescale 1ns/10ps

module ahb_matrix_decode_sva (
    input logic                      HCLK,
    input logic                      HRESETn,
    input logic                      hready_s,
    input ahb_pkg::addr_req_t        addr_req,
    input matrix_map_pkg::port_vec_t sel_out,
    input logic                      sel_dft,
    input ahb_pkg::slv_rsp_t         dft_rsp
);

    int assert_fails = 0;   // Read back by the testbench

    // At most one output port selected
    a_sel_onehot: assert property (@(posedge HCLK) disable iff (!HRESETn)
        $onehot0(sel_out))
    else
    begin
        assert_fails = assert_fails + 1;
        $error("sel_out has more than one bit set: %b", sel_out);
    end

    // No select without HSEL on the input
    a_sel_idle: assert property (@(posedge HCLK) disable iff (!HRESETn)
        !addr_req.sel |-> (sel_out == '0))
    else
    begin
        assert_fails = assert_fails + 1;
        $error("sel_out not zero while input HSEL is low");
    end

    // Wait-state ERROR completes next cycle unless a new transfer restarts it
    a_dft_error_pair: assert property (@(posedge HCLK) disable iff (!HRESETn)
        (!dft_rsp.readyout && (dft_rsp.resp == ahb_pkg::HRESP_ERROR) &&
         !(sel_dft && hready_s))
        |=> (dft_rsp.readyout && (dft_rsp.resp == ahb_pkg::HRESP_ERROR)))
    else
    begin
        assert_fails = assert_fails + 1;
        $error("default slave ERROR not completed in the second cycle");
    end

endmodule

bind ahb_matrix_decode ahb_matrix_decode_sva u_ahb_matrix_decode_sva (
    .HCLK     (HCLK),
    .HRESETn  (HRESETn),
    .hready_s (hready_s),
    .addr_req (addr_req),
    .sel_out  (sel_out),
    .sel_dft  (sel_dft),
    .dft_rsp  (dft_rsp)
);

/* tests/tb_ahb_matrix_decode.sv */
// ----------------------------------------------------------
// Testbench for the per-input matrix decode stage
// Clock, reset, slave models, directed and random stimulus,
// reference model, compare tasks and watchdog
// ----------------------------------------------------------

`timescale 1ns/10ps

module tb_ahb_matrix_decode;

    localparam int CLK_PERIOD      = 8;     // ns
    localparam int STIM_DELAY      = 1;     // Drive point after the rising edge
    localparam int RESET_CYCLES    = 4;
    localparam int DIRECTED_CYCLES = 22;
    localparam int RANDOM_CYCLES   = 500;
    localparam int RUN_CYCLES      = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES;

    logic                      HCLK;
    logic                      HRESETn;
    logic                      hready_s;
    ahb_pkg::addr_req_t        addr_req;
    matrix_map_pkg::port_vec_t active_in;
    ahb_pkg::slv_rsp_t [matrix_map_pkg::NUM_PORTS-1:0] port_rsp;
    matrix_map_pkg::port_vec_t sel_out;
    logic                      active;
    ahb_pkg::slv_rsp_t         s_rsp;

    integer seed;                               // $random state

    // Reference state
    matrix_map_pkg::port_sel_t data_port_m;     // Modeled data-phase port
    logic                      dft_first_m;     // Modeled ERROR wait state
    logic                      dft_last_m;      // Modeled ERROR completion

    ahb_matrix_decode u_ahb_matrix_decode (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .hready_s  (hready_s),
        .addr_req  (addr_req),
        .active_in (active_in),
        .port_rsp  (port_rsp),
        .sel_out   (sel_out),
        .active    (active),
        .s_rsp     (s_rsp)
    );

    initial HCLK = 1'b0;
    always #(CLK_PERIOD / 2) HCLK = ~HCLK;

    // ------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------
    // Region table in 1 KB units, first match wins
    function automatic matrix_map_pkg::port_sel_t expected_port(
        input ahb_pkg::dec_addr_t        addr,
        input logic [1:0]                trans,
        input matrix_map_pkg::port_sel_t cur_port
    );
        matrix_map_pkg::port_sel_t port;
        if (addr <= 22'h0003FF)
            port = matrix_map_pkg::PORT_MI0;
        else if (addr >= 22'h080000 && addr <= 22'h0800FF)
            port = matrix_map_pkg::PORT_MI1;
        else if (addr >= 22'h100000 && addr <= 22'h10003F)
            port = matrix_map_pkg::PORT_MI2;
        else if (addr >= 22'h100040 && addr <= 22'h10007F)
            port = matrix_map_pkg::PORT_MI3;
        else if (addr >= 22'h100080 && addr <= 22'h1000BF)
            port = matrix_map_pkg::PORT_MI4;
        else if (trans == ahb_pkg::HTRANS_IDLE)
            port = cur_port;                        // IDLE stays on data-phase owner
        else
            port = matrix_map_pkg::PORT_DFT;
        return port;
    endfunction

    always @(posedge HCLK)
    begin : model_update
        matrix_map_pkg::port_sel_t acc_port;
        acc_port = expected_port(addr_req.addr, addr_req.trans, data_port_m);
        if (!HRESETn)
        begin
            data_port_m <= matrix_map_pkg::PORT_MI0;
            dft_first_m <= 1'b0;
            dft_last_m  <= 1'b0;
        end
        else
        begin
            if (hready_s)
                data_port_m <= acc_port;            // Address phase accepted
            dft_first_m <= addr_req.sel && hready_s &&
                           (acc_port == matrix_map_pkg::PORT_DFT) &&
                           ((addr_req.trans == ahb_pkg::HTRANS_NONSEQ) ||
                            (addr_req.trans == ahb_pkg::HTRANS_SEQ));
            dft_last_m  <= dft_first_m;             // Second ERROR cycle
        end
    end

    // ------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------
    task automatic stop_on_error();
        $display("TESTS FAILED");
        $fatal(1, "Run stopped at first mismatch");
    endtask

    task automatic check_sel(input matrix_map_pkg::port_vec_t exp_val,
                             input matrix_map_pkg::port_vec_t act_val);
        if (act_val !== exp_val)
        begin
            $display("CHECK FAILED at %0t: sel_out expected %b actual %b",
                     $time, exp_val, act_val);
            stop_on_error();
        end
    endtask

    task automatic check_active(input logic exp_val, input logic act_val);
        if (act_val !== exp_val)
        begin
            $display("CHECK FAILED at %0t: active expected %b actual %b",
                     $time, exp_val, act_val);
            stop_on_error();
        end
    endtask

    task automatic check_rsp(input ahb_pkg::slv_rsp_t exp_val,
                             input ahb_pkg::slv_rsp_t act_val);
        if (act_val !== exp_val)
        begin
            $display("CHECK FAILED at %0t: s_rsp expected %b/%b/%h actual %b/%b/%h",
                     $time, exp_val.readyout, exp_val.resp, exp_val.rdata,
                     act_val.readyout, act_val.resp, act_val.rdata);
            stop_on_error();
        end
    endtask

    // Sample 1 ns before each rising edge, outputs settled
    initial
    begin : compare_loop
        matrix_map_pkg::port_sel_t exp_port;
        matrix_map_pkg::port_vec_t exp_sel;
        logic                      exp_active;
        ahb_pkg::slv_rsp_t         exp_rsp;
        forever
        begin
            @(posedge HCLK);
            #(CLK_PERIOD - 1);
            if (HRESETn)
            begin
                exp_port = expected_port(addr_req.addr, addr_req.trans, data_port_m);
                exp_sel  = '0;
                exp_active = 1'b1;                  // Default slave is always active
                if (exp_port != matrix_map_pkg::PORT_DFT)
                begin
                    exp_sel[int'(exp_port)] = addr_req.sel;
                    exp_active = active_in[int'(exp_port)];
                end
                if (data_port_m == matrix_map_pkg::PORT_DFT)
                begin
                    exp_rsp.readyout = !dft_first_m;
                    exp_rsp.resp     = (dft_first_m || dft_last_m) ?
                                       ahb_pkg::HRESP_ERROR : ahb_pkg::HRESP_OKAY;
                    exp_rsp.rdata    = '0;
                end
                else
                    exp_rsp = port_rsp[int'(data_port_m)];
                check_sel(exp_sel, sel_out);
                check_active(exp_active, active);
                check_rsp(exp_rsp, s_rsp);
            end
            // Bound assertions fired at the last edge
            if (u_ahb_matrix_decode.u_ahb_matrix_decode_sva.assert_fails != 0)
            begin
                $display("A bound assertion failed at %0t", $time);
                stop_on_error();
            end
        end
    end

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------
    task automatic randomize_slaves();
        active_in = matrix_map_pkg::port_vec_t'($random(seed));
        for (int i = 0; i < matrix_map_pkg::NUM_PORTS; i++)
        begin
            port_rsp[i].readyout = ($random(seed) & 3) != 0;   // Mostly ready
            port_rsp[i].resp     = ($random(seed) & 1) ? ahb_pkg::HRESP_ERROR
                                                       : ahb_pkg::HRESP_OKAY;
            port_rsp[i].rdata    = $random(seed);
        end
    endtask

    // One cycle of address phase, then on to the next drive point
    task automatic drive_cycle(input logic sel, input ahb_pkg::dec_addr_t addr,
                               input logic [1:0] trans, input logic rdy);
        addr_req.sel   = sel;
        addr_req.addr  = addr;
        addr_req.trans = trans;
        hready_s       = rdy;
        randomize_slaves();
        @(posedge HCLK);
        #STIM_DELAY;
    endtask

    // Addresses aimed at region edges and the gaps next to them
    task automatic random_cycle();
        int unsigned        region;
        ahb_pkg::dec_addr_t addr;
        region = $unsigned($random(seed)) % matrix_map_pkg::NUM_PORTS;
        case ($unsigned($random(seed)) % 5)
            0:       addr = matrix_map_pkg::REGION_BASE[region];
            1:       addr = matrix_map_pkg::REGION_LIMIT[region];
            2:       addr = matrix_map_pkg::REGION_BASE[region] - 1'b1;
            3:       addr = matrix_map_pkg::REGION_LIMIT[region] + 1'b1;
            default: addr = ahb_pkg::dec_addr_t'($random(seed));
        endcase
        drive_cycle(($random(seed) & 7) != 0, addr, 2'($random(seed)),
                    ($random(seed) & 3) != 0);
    endtask

    initial
    begin
        seed      = 32'h4a6b;
        HRESETn   = 1'b0;
        hready_s  = 1'b0;
        addr_req  = '0;
        active_in = '0;
        port_rsp  = '0;
        repeat (RESET_CYCLES) @(posedge HCLK);
        #STIM_DELAY;
        HRESETn = 1'b1;

        // Right after reset MI0 owns the data phase
        drive_cycle(1'b1, 22'h200000, ahb_pkg::HTRANS_IDLE, 1'b1);
        drive_cycle(1'b1, 22'h3F0000, ahb_pkg::HTRANS_IDLE, 1'b1);

        // Lowest and highest address of each region
        for (int p = 0; p < matrix_map_pkg::NUM_PORTS; p++)
        begin
            drive_cycle(1'b1, matrix_map_pkg::REGION_BASE[p], ahb_pkg::HTRANS_NONSEQ, 1'b1);
            drive_cycle(1'b1, matrix_map_pkg::REGION_LIMIT[p], ahb_pkg::HTRANS_NONSEQ, 1'b1);
        end

        // Unmapped NONSEQ, wait state with HREADY low, then completion
        drive_cycle(1'b1, 22'h300000, ahb_pkg::HTRANS_NONSEQ, 1'b1);
        drive_cycle(1'b0, 22'h000000, ahb_pkg::HTRANS_IDLE, 1'b0);
        drive_cycle(1'b0, 22'h000000, ahb_pkg::HTRANS_IDLE, 1'b1);
        drive_cycle(1'b0, 22'h000000, ahb_pkg::HTRANS_IDLE, 1'b1);

        // Back-pressure holds MI1 while the address points at MI3
        drive_cycle(1'b1, matrix_map_pkg::REGION_BASE[1], ahb_pkg::HTRANS_NONSEQ, 1'b1);
        drive_cycle(1'b1, matrix_map_pkg::REGION_BASE[3], ahb_pkg::HTRANS_NONSEQ, 1'b0);
        drive_cycle(1'b1, matrix_map_pkg::REGION_BASE[3], ahb_pkg::HTRANS_NONSEQ, 1'b0);
        drive_cycle(1'b1, matrix_map_pkg::REGION_BASE[3], ahb_pkg::HTRANS_NONSEQ, 1'b1);

        // Unmapped IDLE stays on MI2
        drive_cycle(1'b1, matrix_map_pkg::REGION_BASE[2], ahb_pkg::HTRANS_NONSEQ, 1'b1);
        drive_cycle(1'b1, 22'h3F0000, ahb_pkg::HTRANS_IDLE, 1'b1);

        repeat (RANDOM_CYCLES) random_cycle();

        if (u_ahb_matrix_decode.u_ahb_matrix_decode_sva.assert_fails == 0)
        begin
            $display("TESTS PASSED");
        end
        else
        begin
            $display("Assertion failures: %0d",
                     u_ahb_matrix_decode.u_ahb_matrix_decode_sva.assert_fails);
            $display("TESTS FAILED");
        end
        $finish;
    end

    // Watchdog, whole run plus margin
    initial
    begin
        #((RUN_CYCLES + 50) * CLK_PERIOD);
        $display("Watchdog expired before the stimulus finished");
        $display("TESTS FAILED");
        $fatal(1, "Timeout");
    end

endmodule

/* src.f */
common/ahb_pkg.sv
common/matrix_map_pkg.sv
decode/matrix_addr_stage.sv
decode/matrix_data_stage.sv
default_slave/ahb_default_slave.sv
logic/ahb_matrix_decode.sv
tests/ahb_matrix_decode_sva.sv
tests/tb_ahb_matrix_decode.sv

/* Bender.yml */
package:
  name: ahb_matrix_decode

sources:
  - files:
      - common/ahb_pkg.sv
      - common/matrix_map_pkg.sv
      - decode/matrix_addr_stage.sv
      - decode/matrix_data_stage.sv
      - default_slave/ahb_default_slave.sv
      - logic/ahb_matrix_decode.sv
  - target: test
    files:
      - tests/ahb_matrix_decode_sva.sv
      - tests/tb_ahb_matrix_decode.sv
